// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam word_t HALT_INST = 32'h8000_0000;

    // RV32 major opcodes in use
    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_I     = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // LUI
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef union packed {
        inst_r_t r;
        inst_s_t s;  // Stores only
    } inst_u;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_we;
        logic      mem_re;
        wb_sel_e   wb_sel;
        logic      halt;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t rs1_val;
        word_t rs2_val;
    } id_ex_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t alu_res;
        word_t store_data;
    } ex_mem_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t alu_res;
        word_t load_data;
        word_t store_data;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        logic      halt;
        logic      reg_we;
        reg_addr_t reg_wa;
        word_t     reg_wd;
        logic      dmem_we;
        word_t     dmem_wa;
        word_t     dmem_wd;
    } commit_t;

endpackage

`default_nettype wire

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
    input  inst_u inst,
    output ctrl_t ctrl
);

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        ctrl.halt   = (inst == HALT_INST);
        ctrl.rs1    = inst.r.rs1;
        ctrl.rs2    = inst.r.rs2;
        ctrl.rd     = inst.r.rd;

        case (inst.r.opcode)
            OP_R: begin
                ctrl.reg_we = 1'b1;
                case (inst.r.funct3)
                    3'b000:  ctrl.alu_op = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b101:  ctrl.alu_op = ALU_SRL;
                    default: ctrl.reg_we = 1'b0;
                endcase
            end
            OP_I, OP_LOAD: begin
                ctrl.rs2     = '0;  // No second source
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
                ctrl.reg_we  = 1'b1;
                if (inst.r.opcode == OP_LOAD) begin
                    ctrl.mem_re = 1'b1;
                    ctrl.wb_sel = WB_MEM;
                end else begin
                    case (inst.r.funct3)
                        3'b000:  ctrl.alu_op = ALU_ADD;
                        3'b111:  ctrl.alu_op = ALU_AND;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b010:  ctrl.alu_op = ALU_SLT;
                        default: ctrl.reg_we = 1'b0;
                    endcase
                end
            end
            OP_STORE: begin
                ctrl.rs1     = inst.s.rs1;
                ctrl.rs2     = inst.s.rs2;
                ctrl.rd      = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
                ctrl.mem_we  = 1'b1;
            end
            OP_LUI: begin
                ctrl.rs1     = '0;
                ctrl.rs2     = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.reg_we  = 1'b1;
            end
            default: begin
                // Unknown opcode or halt writes nothing
                ctrl.rs1 = '0;
                ctrl.rs2 = '0;
                ctrl.rd  = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t ra0,
    input  reg_addr_t ra1,
    input  reg_addr_t wa,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd0,
    output word_t     rd1
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is visible to the read
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  ctrl_t     ex_ctrl,
    input  ctrl_t     mem_ctrl,
    input  ctrl_t     wb_ctrl,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      stall
);

    // Youngest producer wins
    function automatic fwd_sel_e fwd_pick(reg_addr_t rs, ctrl_t mem, ctrl_t wb);
        if (rs == '0)
            return FWD_REG;
        if (mem.reg_we && mem.rd == rs)
            return FWD_MEM;
        if (wb.reg_we && wb.rd == rs)
            return FWD_WB;
        return FWD_REG;
    endfunction

    logic ex_is_load;
    logic rd_match;

    assign fwd_a = fwd_pick(ex_rs1, mem_ctrl, wb_ctrl);
    assign fwd_b = fwd_pick(ex_rs2, mem_ctrl, wb_ctrl);

    assign ex_is_load = ex_ctrl.mem_re && ex_ctrl.rd != '0;
    assign rd_match   = (ex_ctrl.rd == id_rs1) || (ex_ctrl.rd == id_rs2);

    // Load data is not ready before WB
    assign stall = ex_is_load && rd_match;

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  word_t rs1_val,
    input  word_t rs2_val,
    input  ctrl_t ctrl,
    output word_t res
);

    word_t     op_a;
    word_t     op_b;
    logic [4:0] shamt;

    assign op_a  = rs1_val;
    assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    res = op_a + op_b;
            ALU_SUB:    res = op_a - op_b;
            ALU_AND:    res = op_a & op_b;
            ALU_OR:     res = op_a | op_b;
            ALU_XOR:    res = op_a ^ op_b;
            ALU_SLT:    res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    res = op_a << shamt;
            ALU_SRL:    res = op_a >> shamt;  // Logical
            ALU_PASS_B: res = op_b;
            default:    res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic    clk,
    input  logic    rst,
    output word_t   imem_raddr,
    input  word_t   imem_rdata,
    output word_t   dmem_addr,
    output logic    dmem_we,
    output word_t   dmem_wdata,
    input  word_t   dmem_rdata,
    output commit_t commit_out
);

    word_t    pc;
    logic     if_valid;
    word_t    if_pc;
    word_t    if_inst;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    ctrl_t    id_ctrl;
    word_t    id_rs1_val;
    word_t    id_rs2_val;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     load_use;
    logic     stall;
    word_t    fwd_rs1;
    word_t    fwd_rs2;
    word_t    ex_res;
    word_t    wb_data;
    logic     freeze;
    logic     halted;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign freeze = mem_wb.valid && mem_wb.ctrl.halt;  // Halt reached WB
    assign stall  = load_use && if_valid;

    // IF
    assign imem_raddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else if (!freeze && !stall) begin
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
            if_pc    <= pc;
            if_inst  <= imem_rdata;
        end
    end

    // ID
    decoder u_decoder (.inst(if_inst), .ctrl(id_ctrl));

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .ra0 (id_ctrl.rs1),
        .ra1 (id_ctrl.rs2),
        .wa  (mem_wb.ctrl.rd),
        .we  (mem_wb.valid && mem_wb.ctrl.reg_we),
        .wd  (wb_data),
        .rd0 (id_rs1_val),
        .rd1 (id_rs2_val)
    );

    hazard_unit u_hazard_unit (
        .ex_rs1   (id_ex.ctrl.rs1),
        .ex_rs2   (id_ex.ctrl.rs2),
        .id_rs1   (id_ctrl.rs1),
        .id_rs2   (id_ctrl.rs2),
        .ex_ctrl  (id_ex.ctrl),
        .mem_ctrl (ex_mem.ctrl),
        .wb_ctrl  (mem_wb.ctrl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .stall    (load_use)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else if (!freeze) begin
            if (stall || !if_valid)
                id_ex <= '0;  // Bubble
            else
                id_ex <= '{valid: 1'b1, pc: if_pc, inst: if_inst, ctrl: id_ctrl,
                           rs1_val: id_rs1_val, rs2_val: id_rs2_val};
        end
    end

    // EX
    assign fwd_rs1 = fwd_mux(fwd_a, id_ex.rs1_val, ex_mem.alu_res, wb_data);
    assign fwd_rs2 = fwd_mux(fwd_b, id_ex.rs2_val, ex_mem.alu_res, wb_data);

    alu u_alu (.rs1_val(fwd_rs1), .rs2_val(fwd_rs2), .ctrl(id_ex.ctrl), .res(ex_res));

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else if (!freeze) begin
            ex_mem <= '{valid: id_ex.valid, pc: id_ex.pc, inst: id_ex.inst,
                        ctrl: id_ex.ctrl, alu_res: ex_res, store_data: fwd_rs2};
        end
    end

    // MEM
    assign dmem_addr  = ex_mem.alu_res;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.valid && ex_mem.ctrl.mem_we && !freeze;  // No stores once halted

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
            mem_wb.ctrl  <= '0;
        end else if (!freeze) begin
            mem_wb <= '{valid: ex_mem.valid, pc: ex_mem.pc, inst: ex_mem.inst,
                        ctrl: ex_mem.ctrl, alu_res: ex_mem.alu_res,
                        load_data: dmem_rdata, store_data: ex_mem.store_data};
        end
    end

    // WB and commit
    assign wb_data = (mem_wb.ctrl.wb_sel == WB_MEM) ? mem_wb.load_data : mem_wb.alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_out.valid   <= 1'b0;
            commit_out.reg_we  <= 1'b0;
            commit_out.dmem_we <= 1'b0;
            halted             <= 1'b0;
        end else begin
            commit_out <= '{valid: mem_wb.valid && !halted, pc: mem_wb.pc,
                            inst: mem_wb.inst, halt: mem_wb.ctrl.halt,
                            reg_we: mem_wb.ctrl.reg_we, reg_wa: mem_wb.ctrl.rd,
                            reg_wd: wb_data, dmem_we: mem_wb.ctrl.mem_we,
                            dmem_wa: mem_wb.alu_res, dmem_wd: mem_wb.store_data};
            halted <= halted || freeze;  // Halt commits once
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

    // Load-use bubble keeps a load out of the MEM forward path
    a_no_load_fwd: assert property (@(posedge clk) disable iff (rst)
        (fwd_a == FWD_MEM || fwd_b == FWD_MEM) |-> !ex_mem.ctrl.mem_re);

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam word_t RESET_PC   = 32'h0000_0100;
    localparam int    PAT_WORDS  = 512;
    localparam int    IMEM_WORDS = 64;

    logic    clk;
    logic    rst;
    word_t   imem_raddr;
    word_t   imem_rdata;
    word_t   dmem_addr;
    logic    dmem_we;
    word_t   dmem_wdata;
    word_t   dmem_rdata;
    commit_t commit_out;

    word_t pat [PAT_WORDS];
    word_t imem [IMEM_WORDS];
    word_t dmem [256];
    word_t fetch_idx;
    int    n_prog;
    int    n_rec;
    int    rec_idx;
    int    checks;
    int    errors;
    logic  loaded;
    logic  halt_seen;

    cpu_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk        (clk),
        .rst        (rst),
        .imem_raddr (imem_raddr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .commit_out (commit_out)
    );

    always #2 clk = ~clk;

    // Fetches past the program see zero words
    assign fetch_idx  = (imem_raddr - RESET_PC) >> 2;
    assign imem_rdata = (fetch_idx < IMEM_WORDS) ? imem[fetch_idx] : '0;

    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (!rst && dmem_we === 1'b1)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic match_commit();
        int    base;
        word_t exp_inst;
        if (halt_seen) begin
            errors++;
            $display("A commit at pc %h arrived after the halt", commit_out.pc);
        end else if (rec_idx >= n_rec) begin
            errors++;
            $display("A commit at pc %h has no expected record", commit_out.pc);
        end else begin
            base     = 2 + n_prog + 8 * rec_idx;
            exp_inst = pat[base+1];
            check_value("commit_out.pc", commit_out.pc, pat[base]);
            check_value("commit_out.inst", commit_out.inst, exp_inst);
            check_value("commit_out.halt", word_t'(commit_out.halt),
                        word_t'(exp_inst == 32'h8000_0000));
            check_value("commit_out.reg_we", word_t'(commit_out.reg_we), pat[base+2]);
            check_value("commit_out.dmem_we", word_t'(commit_out.dmem_we), pat[base+5]);
            if (pat[base+2] == 32'd1) begin
                check_value("commit_out.reg_wa", word_t'(commit_out.reg_wa), pat[base+3]);
                check_value("commit_out.reg_wd", commit_out.reg_wd, pat[base+4]);
            end
            if (pat[base+5] == 32'd1) begin  // Store address and data
                check_value("commit_out.dmem_wa", commit_out.dmem_wa, pat[base+6]);
                check_value("commit_out.dmem_wd", commit_out.dmem_wd, pat[base+7]);
            end
            rec_idx++;
        end
        if (commit_out.halt === 1'b1)
            halt_seen = 1'b1;
    endtask

    // Commit fields are settled by the falling edge
    always @(negedge clk) begin
        if (loaded && !rst && commit_out.valid === 1'b1)
            match_commit();
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        loaded    = 1'b0;
        halt_seen = 1'b0;
        rec_idx   = 0;
        checks    = 0;
        errors    = 0;
        n_prog    = 0;
        n_rec     = 0;
        for (int i = 0; i < 256; i++)
            dmem[i] = '0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;
        $readmemh("tests/cpu_patterns.txt", pat);
        if ($isunknown(pat[0]) || $isunknown(pat[1]) || pat[0] > IMEM_WORDS
                || 2 + pat[0] + 8 * pat[1] > PAT_WORDS) begin
            errors++;
            $display("The pattern file is missing or its header is malformed");
        end else begin
            n_prog = pat[0];
            n_rec  = pat[1];
        end
        for (int i = 0; i < n_prog; i++)
            imem[i] = pat[2+i];
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    // Ten cycles per program word plus margin
    initial begin
        wait (loaded === 1'b1);
        repeat (10 * n_prog + 50) @(posedge clk);
        if (!halt_seen) begin
            errors++;
            $display("The watchdog expired before the halt committed");
        end
        if (rec_idx != n_rec) begin
            errors++;
            $display("Only %0d of %0d expected commits arrived", rec_idx, n_rec);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/cpu_pkg.sv
src/decoder.sv
src/reg_file.sv
src/hazard_unit.sv
src/alu.sv
src/cpu_core.sv
tests/cpu_tb.sv

// ==== tests/cpu_patterns.txt ====
// Header: program word count, commit record count; then program words from RESET_PC
// Records: pc inst reg_we reg_wa reg_wd dmem_we dmem_wa dmem_wd
00000017 00000017
00500093 ffd00113 002081b3 40208233
001122b3 00309333 001153b3 12345437
67846493 0ff4f513 fff54593 ffe12613
00b4f6b3 0041e733 004547b3 00932823
02402803 001808b3 00500013 00000933
ff132e23 01002983 80000000
00000100 00500093 1 01 00000005 0 00000000 00000000
00000104 ffd00113 1 02 fffffffd 0 00000000 00000000
00000108 002081b3 1 03 00000002 0 00000000 00000000
0000010c 40208233 1 04 00000008 0 00000000 00000000
00000110 001122b3 1 05 00000001 0 00000000 00000000
00000114 00309333 1 06 00000014 0 00000000 00000000
00000118 001153b3 1 07 07ffffff 0 00000000 00000000
0000011c 12345437 1 08 12345000 0 00000000 00000000
00000120 67846493 1 09 12345678 0 00000000 00000000
00000124 0ff4f513 1 0a 00000078 0 00000000 00000000
00000128 fff54593 1 0b ffffff87 0 00000000 00000000
0000012c ffe12613 1 0c 00000001 0 00000000 00000000
00000130 00b4f6b3 1 0d 12345600 0 00000000 00000000
00000134 0041e733 1 0e 0000000a 0 00000000 00000000
00000138 004547b3 1 0f 00000070 0 00000000 00000000
0000013c 00932823 0 00 00000000 1 00000024 12345678
00000140 02402803 1 10 12345678 0 00000000 00000000
00000144 001808b3 1 11 1234567d 0 00000000 00000000
00000148 00500013 1 00 00000005 0 00000000 00000000
0000014c 00000933 1 12 00000000 0 00000000 00000000
00000150 ff132e23 0 00 00000000 1 00000010 1234567d
00000154 01002983 1 13 1234567d 0 00000000 00000000
00000158 80000000 0 00 00000000 0 00000000 00000000
